//--- hdl/conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// filters computed side by side
`define CONV_LANES   8

// accumulator width, wraps on overflow
`define CONV_ACC_W   24

`define CONV_DATA_W  32
`define CONV_ADDR_W  20

// channel count is a multiple of 4 up to this
`define CONV_MAX_CH  64
`define CONV_FROWS   (`CONV_MAX_CH / 4)

// unsigned pixel byte minus this gives int8
`define CONV_PIX_OFS 128

`endif

//--- hdl/conv_pkg.sv
`include "conv_defs.svh"

package conv_pkg;

   typedef struct packed {
      logic [7:0]              channels;   // multiple of 4
      logic [15:0]             pixels;
      logic [`CONV_ADDR_W-1:0] bias_base;
      logic [`CONV_ADDR_W-1:0] filt_base;
      logic [`CONV_ADDR_W-1:0] pix_base;
      logic [`CONV_ADDR_W-1:0] res_base;
      logic [1:0]              shift;
   } conv_cfg_t;

   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      logic                    we;
      logic [`CONV_ADDR_W-1:0] adr;
      logic [`CONV_DATA_W-1:0] dat;
      logic [3:0]              sel;
   } wb_req_t;

   typedef struct packed {
      logic                    ack;
      logic [`CONV_DATA_W-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic                    we;
      logic [`CONV_ADDR_W-1:0] adr;   // byte address, word aligned
      logic [`CONV_DATA_W-1:0] dat;
   } mem_cmd_t;

   typedef enum logic [3:0] {
      SEQ_IDLE, SEQ_BIAS, SEQ_FILT, SEQ_INIT, SEQ_PIX,
      SEQ_MAC, SEQ_QUANT, SEQ_WR0, SEQ_WR1, SEQ_DONE
   } seq_state_e;

   typedef enum logic [1:0] {
      MAC_HOLD, MAC_BIAS, MAC_INIT, MAC_ACCUM
   } mac_op_e;

   // lane 0 in the low slice
   typedef logic [`CONV_LANES-1:0][`CONV_ACC_W-1:0] acc_vec_t;

endpackage

//--- hdl/conv_wb_master.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_wb_master (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    i_cmd_valid,
   input  conv_pkg::mem_cmd_t      i_cmd,
   input  conv_pkg::wb_rsp_t       i_wb,
   output logic                    o_cmd_done,
   output logic [`CONV_DATA_W-1:0] o_rdata,
   output conv_pkg::wb_req_t       o_wb
);

   logic accept;

   // a new command only once the previous done pulse has passed
   assign accept = i_cmd_valid & ~o_wb.cyc & ~o_cmd_done;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_wb       <= '0;
         o_cmd_done <= 1'b0;
      end else begin
         o_cmd_done <= 1'b0;
         if (o_wb.cyc) begin
            if (i_wb.ack) begin
               o_wb.cyc   <= 1'b0;    // single transfer ends here
               o_wb.stb   <= 1'b0;
               o_wb.we    <= 1'b0;
               o_cmd_done <= 1'b1;
            end
         end else if (accept) begin
            o_wb.cyc <= 1'b1;
            o_wb.stb <= 1'b1;
            o_wb.we  <= i_cmd.we;
            o_wb.adr <= i_cmd.adr;    // held through wait states
            o_wb.dat <= i_cmd.dat;
            o_wb.sel <= '1;
         end
      end
   end

   // read data sampled in the ack cycle
   always_ff @(posedge clk) begin
      if (o_wb.cyc && i_wb.ack && !o_wb.we) begin
         o_rdata <= i_wb.dat;
      end
   end

endmodule

//--- hdl/conv_seq.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_seq (
   input  logic                              clk,
   input  logic                              rstn,
   input  logic                              i_start,
   input  conv_pkg::conv_cfg_t               i_cfg,
   input  logic                              i_cmd_done,
   input  logic [`CONV_DATA_W-1:0]           i_rdata,
   input  logic [`CONV_DATA_W-1:0]           i_res0,
   input  logic [`CONV_DATA_W-1:0]           i_res1,
   output logic                              o_cmd_valid,
   output conv_pkg::mem_cmd_t                o_cmd,
   output logic [`CONV_LANES-1:0]            o_fram_we,
   output logic [$clog2(`CONV_FROWS)-1:0]    o_fram_row,
   output logic [`CONV_DATA_W-1:0]           o_fram_wdata,
   output conv_pkg::mac_op_e                 o_mac_op,
   output logic [$clog2(`CONV_LANES)-1:0]    o_mac_lane,
   output logic [`CONV_DATA_W-1:0]           o_mac_data,
   output logic                              o_quant_en,
   output logic                              o_done
);

   localparam int RW = $clog2(`CONV_FROWS);
   localparam int LW = $clog2(`CONV_LANES);
   localparam logic [LW-1:0] LAST_LANE = LW'(`CONV_LANES - 1);
   localparam logic [`CONV_ADDR_W-1:0] WORD_BYTES = 4;

   conv_pkg::seq_state_e    state;
   logic [LW-1:0]           lane_cnt;
   logic [RW-1:0]           word_cnt;   // channel group within a filter or pixel
   logic [RW-1:0]           last_word;
   logic [15:0]             pix_cnt;
   logic [`CONV_ADDR_W-1:0] pix_addr;
   logic [`CONV_ADDR_W-1:0] res_addr;

   assign last_word = RW'(i_cfg.channels[7:2] - 6'd1);

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state        <= conv_pkg::SEQ_IDLE;
         lane_cnt     <= '0;
         word_cnt     <= '0;
         pix_cnt      <= '0;
         pix_addr     <= '0;
         res_addr     <= '0;
         o_cmd_valid  <= 1'b0;
         o_cmd        <= '0;
         o_fram_we    <= '0;
         o_fram_row   <= '0;
         o_fram_wdata <= '0;
         o_mac_op     <= conv_pkg::MAC_HOLD;
         o_mac_lane   <= '0;
         o_mac_data   <= '0;
         o_quant_en   <= 1'b0;
         o_done       <= 1'b0;
      end else begin
         o_fram_we  <= '0;
         o_mac_op   <= conv_pkg::MAC_HOLD;
         o_quant_en <= 1'b0;
         case (state)
            conv_pkg::SEQ_IDLE: begin
               if (i_start) begin
                  o_cmd_valid <= 1'b1;
                  o_cmd       <= '{we: 1'b0, adr: i_cfg.bias_base, dat: '0};
                  lane_cnt    <= '0;
                  pix_cnt     <= '0;
                  pix_addr    <= i_cfg.pix_base;
                  res_addr    <= i_cfg.res_base;
                  state       <= conv_pkg::SEQ_BIAS;
               end
            end
            conv_pkg::SEQ_BIAS: begin
               if (i_cmd_done) begin
                  o_mac_op   <= conv_pkg::MAC_BIAS;
                  o_mac_lane <= lane_cnt;
                  o_mac_data <= i_rdata;
                  lane_cnt   <= lane_cnt + 1'b1;   // wraps to lane 0 for filters
                  if (lane_cnt == LAST_LANE) begin
                     o_cmd    <= '{we: 1'b0, adr: i_cfg.filt_base, dat: '0};
                     word_cnt <= '0;
                     state    <= conv_pkg::SEQ_FILT;
                  end else begin
                     o_cmd.adr <= o_cmd.adr + WORD_BYTES;
                  end
               end
            end
            conv_pkg::SEQ_FILT: begin
               if (i_cmd_done) begin
                  o_fram_we[lane_cnt] <= 1'b1;
                  o_fram_row          <= word_cnt;
                  o_fram_wdata        <= i_rdata;
                  o_cmd.adr           <= o_cmd.adr + WORD_BYTES;
                  if (word_cnt == last_word) begin
                     word_cnt <= '0;
                     lane_cnt <= lane_cnt + 1'b1;
                     if (lane_cnt == LAST_LANE) begin
                        o_cmd_valid <= 1'b0;
                        state       <= conv_pkg::SEQ_INIT;
                     end
                  end else begin
                     word_cnt <= word_cnt + 1'b1;
                  end
               end
            end
            conv_pkg::SEQ_INIT: begin
               o_mac_op    <= conv_pkg::MAC_INIT;   // accumulators from bias
               word_cnt    <= '0;
               o_cmd_valid <= 1'b1;
               o_cmd       <= '{we: 1'b0, adr: pix_addr, dat: '0};
               pix_addr    <= pix_addr + WORD_BYTES;
               state       <= conv_pkg::SEQ_PIX;
            end
            conv_pkg::SEQ_PIX: begin
               if (i_cmd_done) begin
                  o_fram_row  <= word_cnt;   // weights for this channel group
                  o_mac_data  <= i_rdata;
                  o_cmd_valid <= 1'b0;
                  state       <= conv_pkg::SEQ_MAC;
               end
            end
            conv_pkg::SEQ_MAC: begin
               // filter row is out of the RAM by now
               o_mac_op <= conv_pkg::MAC_ACCUM;
               if (word_cnt == last_word) begin
                  state <= conv_pkg::SEQ_QUANT;
               end else begin
                  word_cnt    <= word_cnt + 1'b1;
                  o_cmd_valid <= 1'b1;
                  o_cmd       <= '{we: 1'b0, adr: pix_addr, dat: '0};
                  pix_addr    <= pix_addr + WORD_BYTES;
                  state       <= conv_pkg::SEQ_PIX;
               end
            end
            conv_pkg::SEQ_QUANT: begin
               o_quant_en <= 1'b1;   // last accumulate lands this edge
               state      <= conv_pkg::SEQ_WR0;
            end
            conv_pkg::SEQ_WR0: begin
               if (i_cmd_done) begin
                  o_cmd    <= '{we: 1'b1, adr: res_addr, dat: i_res1};
                  res_addr <= res_addr + WORD_BYTES;
                  state    <= conv_pkg::SEQ_WR1;
               end else if (!o_cmd_valid && !o_quant_en) begin
                  // result words valid one cycle after quant_en
                  o_cmd_valid <= 1'b1;
                  o_cmd       <= '{we: 1'b1, adr: res_addr, dat: i_res0};
                  res_addr    <= res_addr + WORD_BYTES;
               end
            end
            conv_pkg::SEQ_WR1: begin
               if (i_cmd_done) begin
                  o_cmd_valid <= 1'b0;
                  if (pix_cnt == i_cfg.pixels - 16'd1) begin
                     o_done <= 1'b1;
                     state  <= conv_pkg::SEQ_DONE;
                  end else begin
                     pix_cnt <= pix_cnt + 16'd1;
                     state   <= conv_pkg::SEQ_INIT;
                  end
               end
            end
            conv_pkg::SEQ_DONE: begin
               if (!i_start) begin
                  o_done <= 1'b0;
                  state  <= conv_pkg::SEQ_IDLE;
               end
            end
            default: state <= conv_pkg::SEQ_IDLE;
         endcase
      end
   end

endmodule

//--- hdl/conv_filter_ram.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_filter_ram (
   input  logic                                     clk,
   input  logic [`CONV_LANES-1:0]                   i_we,
   input  logic [$clog2(`CONV_FROWS)-1:0]           i_wrow,
   input  logic [`CONV_DATA_W-1:0]                  i_wdata,
   input  logic [$clog2(`CONV_FROWS)-1:0]           i_rrow,
   output logic [`CONV_LANES-1:0][`CONV_DATA_W-1:0] o_row
);

   // one row per channel group, one word per filter lane
   logic [`CONV_LANES-1:0][`CONV_DATA_W-1:0] mem [`CONV_FROWS];

   always_ff @(posedge clk) begin
      for (int l = 0; l < `CONV_LANES; l++) begin
         if (i_we[l]) begin
            mem[i_wrow][l] <= i_wdata;
         end
      end
      o_row <= mem[i_rrow];   // whole row, one cycle late
   end

endmodule

//--- hdl/conv_mac_array.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_mac_array (
   input  logic                                     clk,
   input  logic                                     rstn,
   input  conv_pkg::mac_op_e                        i_op,
   input  logic [$clog2(`CONV_LANES)-1:0]           i_lane,
   input  logic [`CONV_DATA_W-1:0]                  i_data,
   input  logic [`CONV_LANES-1:0][`CONV_DATA_W-1:0] i_row,
   output conv_pkg::acc_vec_t                       o_acc
);

   localparam int NB = `CONV_DATA_W / 8;   // channels per word

   logic [`CONV_LANES-1:0][`CONV_ACC_W-1:0] bias_q;
   logic signed [8:0]                        pix_s [NB];
   logic signed [`CONV_ACC_W-1:0]            lane_sum [`CONV_LANES];

   always_comb begin
      for (int k = 0; k < NB; k++) begin
         // byte 0 sits in the top bits
         pix_s[k] = $signed({1'b0, i_data[`CONV_DATA_W-1-8*k -: 8]}) - 9'(`CONV_PIX_OFS);
      end
      for (int l = 0; l < `CONV_LANES; l++) begin
         lane_sum[l] = '0;
         for (int k = 0; k < NB; k++) begin
            lane_sum[l] = lane_sum[l]
                        + pix_s[k] * $signed(i_row[l][`CONV_DATA_W-1-8*k -: 8]);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_op == conv_pkg::MAC_BIAS) begin
         bias_q[i_lane] <= i_data[`CONV_ACC_W-1:0];   // 24-bit signed bias
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_acc <= '0;
      end else begin
         case (i_op)
            conv_pkg::MAC_INIT: o_acc <= bias_q;
            conv_pkg::MAC_ACCUM: begin
               for (int l = 0; l < `CONV_LANES; l++) begin
                  o_acc[l] <= o_acc[l] + lane_sum[l];   // wraps at 24 bits
               end
            end
            default: o_acc <= o_acc;
         endcase
      end
   end

endmodule

//--- hdl/conv_requant.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_requant (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    i_en,
   input  logic [1:0]              i_shift,
   input  conv_pkg::acc_vec_t      i_acc,
   output logic [`CONV_DATA_W-1:0] o_res0,
   output logic [`CONV_DATA_W-1:0] o_res1
);

   logic signed [`CONV_ACC_W-1:0] shifted [`CONV_LANES];
   logic [`CONV_LANES-1:0][7:0]   sat_b;

   always_comb begin
      for (int l = 0; l < `CONV_LANES; l++) begin
         shifted[l] = $signed(i_acc[l]) >>> i_shift;
         if (shifted[l][`CONV_ACC_W-1]) begin
            sat_b[l] = 8'h00;                          // negative
         end else if (|shifted[l][`CONV_ACC_W-2:8]) begin
            sat_b[l] = 8'hff;                          // above 255
         end else begin
            sat_b[l] = shifted[l][7:0];
         end
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_res0 <= '0;
         o_res1 <= '0;
      end else if (i_en) begin
         o_res0 <= {sat_b[0], sat_b[1], sat_b[2], sat_b[3]};   // lane 0 in 31:24
         o_res1 <= {sat_b[4], sat_b[5], sat_b[6], sat_b[7]};
      end
   end

endmodule

//--- hdl/conv2d_top.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv2d_top (
   input  logic                clk,
   input  logic                rstn,
   input  logic                i_start,
   input  conv_pkg::conv_cfg_t i_cfg,
   input  conv_pkg::wb_rsp_t   i_wb,
   output logic                o_done,
   output conv_pkg::wb_req_t   o_wb
);

   logic                                     cmd_valid;
   conv_pkg::mem_cmd_t                       cmd;
   logic                                     cmd_done;
   logic [`CONV_DATA_W-1:0]                  rdata;
   logic [`CONV_LANES-1:0]                   fram_we;
   logic [$clog2(`CONV_FROWS)-1:0]           fram_row;   // shared write and read row
   logic [`CONV_DATA_W-1:0]                  fram_wdata;
   logic [`CONV_LANES-1:0][`CONV_DATA_W-1:0] frow;
   conv_pkg::mac_op_e                        mac_op;
   logic [$clog2(`CONV_LANES)-1:0]           mac_lane;
   logic [`CONV_DATA_W-1:0]                  mac_data;
   conv_pkg::acc_vec_t                       acc;
   logic                                     quant_en;
   logic [`CONV_DATA_W-1:0]                  res0;
   logic [`CONV_DATA_W-1:0]                  res1;

   conv_seq u_seq (
      .clk          (clk),
      .rstn         (rstn),
      .i_start      (i_start),
      .i_cfg        (i_cfg),
      .i_cmd_done   (cmd_done),
      .i_rdata      (rdata),
      .i_res0       (res0),
      .i_res1       (res1),
      .o_cmd_valid  (cmd_valid),
      .o_cmd        (cmd),
      .o_fram_we    (fram_we),
      .o_fram_row   (fram_row),
      .o_fram_wdata (fram_wdata),
      .o_mac_op     (mac_op),
      .o_mac_lane   (mac_lane),
      .o_mac_data   (mac_data),
      .o_quant_en   (quant_en),
      .o_done       (o_done)
   );

   conv_wb_master u_wb (
      .clk         (clk),
      .rstn        (rstn),
      .i_cmd_valid (cmd_valid),
      .i_cmd       (cmd),
      .i_wb        (i_wb),
      .o_cmd_done  (cmd_done),
      .o_rdata     (rdata),
      .o_wb        (o_wb)
   );

   conv_filter_ram u_fram (
      .clk     (clk),
      .i_we    (fram_we),
      .i_wrow  (fram_row),
      .i_wdata (fram_wdata),
      .i_rrow  (fram_row),
      .o_row   (frow)
   );

   conv_mac_array u_mac (
      .clk    (clk),
      .rstn   (rstn),
      .i_op   (mac_op),
      .i_lane (mac_lane),
      .i_data (mac_data),
      .i_row  (frow),
      .o_acc  (acc)
   );

   conv_requant u_quant (
      .clk     (clk),
      .rstn    (rstn),
      .i_en    (quant_en),
      .i_shift (i_cfg.shift),
      .i_acc   (acc),
      .o_res0  (res0),
      .o_res1  (res1)
   );

endmodule

//--- tb/conv_clk_gen.sv
`timescale 1ns/1ps

module conv_clk_gen (
   output logic o_clk,
   output logic o_rstn
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #2 o_clk = ~o_clk;   // 4 ns period
      end
   end

   initial begin
      o_rstn = 1'b0;
      repeat (2) @(posedge o_clk);
      #1 o_rstn = 1'b1;   // released off the edge
   end

endmodule

//--- tb/conv_wb_chk.sv
`timescale 1ns/1ps

module conv_wb_chk (
   input logic              clk,
   input logic              rstn,
   input logic              i_start,
   input logic              i_done,
   input conv_pkg::wb_req_t i_wb_req,
   input conv_pkg::wb_rsp_t i_wb_rsp
);

   stb_in_cyc: assert property (@(posedge clk) disable iff (!rstn)
      i_wb_req.stb |-> i_wb_req.cyc)
      else $error("stb high without cyc");

   // request fields frozen through wait states
   req_stable: assert property (@(posedge clk) disable iff (!rstn)
      (i_wb_req.stb && !i_wb_rsp.ack) |=>
         ($stable(i_wb_req.adr) && $stable(i_wb_req.we) && $stable(i_wb_req.dat)))
      else $error("request changed before ack");

   stb_drop: assert property (@(posedge clk) disable iff (!rstn)
      (i_wb_req.stb && i_wb_rsp.ack) |=> !i_wb_req.stb)
      else $error("stb still high after ack");

   idle_in_reset: assert property (@(posedge clk)
      !rstn |-> (!i_wb_req.cyc && !i_wb_req.stb))
      else $error("bus active during reset");

   done_held: assert property (@(posedge clk) disable iff (!rstn)
      (i_done && i_start) |=> i_done)
      else $error("done dropped while start high");

endmodule

bind conv2d_top conv_wb_chk u_wb_chk (
   .clk      (clk),
   .rstn     (rstn),
   .i_start  (i_start),
   .i_done   (o_done),
   .i_wb_req (o_wb),
   .i_wb_rsp (i_wb)
);

//--- tb/conv_tb.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_tb;

   localparam int MEM_WORDS = 1 << (`CONV_ADDR_W - 2);
   localparam int RUNS      = 11;
   localparam int DONE_TMO  = 20000;
   localparam int DROP_TMO  = 10;
   localparam int RES_SLOT  = 'h8000;   // result slot, refilled every run

   logic                    clk;
   logic                    rstn;
   logic                    start;
   conv_pkg::conv_cfg_t     cfg;
   conv_pkg::wb_req_t       wb_req;
   conv_pkg::wb_rsp_t       wb_rsp;
   logic                    done;
   logic [31:0]             mem [MEM_WORDS];
   logic [`CONV_ADDR_W-1:0] wr_q [$];   // write addresses of this run
   integer                  seed = 32'h49e6_8c8b;
   int                      errors;
   int                      timeouts;
   int                      wait_left;
   logic                    busy;

   conv_clk_gen u_clk (
      .o_clk  (clk),
      .o_rstn (rstn)
   );

   conv2d_top dut (
      .clk     (clk),
      .rstn    (rstn),
      .i_start (start),
      .i_cfg   (cfg),
      .i_wb    (wb_rsp),
      .o_done  (done),
      .o_wb    (wb_req)
   );

   function automatic int rand_below(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic logic [31:0] fill_word(int widx);
      return (widx * 32'h9e37_79b1) ^ 32'h3c3c_0f0f;
   endfunction

   function automatic logic [7:0] get_byte(int addr);
      logic [31:0] w;
      w = mem[addr >> 2];
      return w[31 - 8 * (addr % 4) -: 8];   // lowest channel on top
   endfunction

   function automatic bit in_region(int a, int base, int len);
      return (a >= base) && (a < base + len);
   endfunction

   function automatic logic [7:0] expect_byte(int p, int lane);
      int          ch;
      int          acc;
      int          px;
      int          w;
      logic [23:0] acc24;
      ch  = cfg.channels;
      acc = 0;
      for (int c = 0; c < ch; c++) begin
         px  = get_byte(cfg.pix_base + p * ch + c) - `CONV_PIX_OFS;
         w   = $signed(get_byte(cfg.filt_base + lane * ch + c));
         acc = acc + px * w;
      end
      acc24 = mem[(cfg.bias_base >> 2) + lane][23:0] + acc[23:0];   // 24-bit wrap
      acc   = $signed(acc24);
      acc   = acc >>> cfg.shift;
      if (acc < 0) begin
         return 8'h00;
      end else if (acc > 255) begin
         return 8'hff;
      end
      return acc[7:0];
   endfunction

   function automatic logic [31:0] expect_word(int p, int half);
      logic [31:0] w;
      for (int k = 0; k < 4; k++) begin
         w[31 - 8 * k -: 8] = expect_byte(p, 4 * half + k);
      end
      return w;
   endfunction

   task automatic report_error(input string msg);
      $display("** Error @ %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at %0t ns: %s did not happen in time", $time, what);
      timeouts++;
   endtask

   task automatic serve_transfer();
      int a;
      int ch;
      a  = wb_req.adr;
      ch = cfg.channels;
      assert (wb_req.sel === 4'hf)
         else report_error($sformatf("sel %h at %h, expected all ones", wb_req.sel, a));
      if (wb_req.we) begin
         assert (in_region(a, cfg.res_base, 8 * cfg.pixels))
            else report_error($sformatf("write outside result region at %h", a));
         wr_q.push_back(wb_req.adr);
         mem[a >> 2] = wb_req.dat;
      end else begin
         assert (in_region(a, cfg.bias_base, 4 * `CONV_LANES)
                 || in_region(a, cfg.filt_base, `CONV_LANES * ch)
                 || in_region(a, cfg.pix_base, cfg.pixels * ch))
            else report_error($sformatf("read outside input regions at %h", a));
         wb_rsp.dat = mem[a >> 2];
      end
   endtask

   // slave with 0 to 3 wait states per transfer
   always @(posedge clk) begin
      #1;
      if (wb_rsp.ack) begin
         wb_rsp.ack = 1'b0;
      end else if (wb_req.cyc && wb_req.stb) begin
         if (!busy) begin
            busy      = 1'b1;
            wait_left = rand_below(4);
         end
         if (wait_left == 0) begin
            busy = 1'b0;
            serve_transfer();
            wb_rsp.ack = 1'b1;
         end else begin
            wait_left--;
         end
      end
   end

   task automatic setup_run(input bit saturate);
      int          ch;
      int          w;
      logic [23:0] bias;
      ch           = 4 * (1 + rand_below(`CONV_MAX_CH / 4));
      cfg.channels = 8'(ch);
      cfg.pixels   = 16'(1 + rand_below(6));
      cfg.shift    = 2'(rand_below(4));
      cfg.bias_base = 20'('h1000 + 4 * rand_below(64));
      cfg.filt_base = 20'('h2000 + 4 * rand_below(64));
      cfg.pix_base  = 20'('h4000 + 4 * rand_below(64));
      cfg.res_base  = 20'(RES_SLOT + 4 * rand_below(64));
      for (int l = 0; l < `CONV_LANES; l++) begin
         if (saturate) begin
            bias = (l < 4) ? 24'h3f_0000 : 24'hc1_0000;
         end else begin
            w    = rand_below(8192) - 4096;
            bias = w[23:0];
         end
         mem[(cfg.bias_base >> 2) + l] = {8'(rand_below(256)), bias};   // junk top byte
      end
      for (int a = 0; a < `CONV_LANES * ch; a++) begin
         w = rand_below(15) - 7;
         mem[(cfg.filt_base + a) >> 2][31 - 8 * (a % 4) -: 8] = w[7:0];
      end
      for (int a = 0; a < cfg.pixels * ch; a++) begin
         mem[(cfg.pix_base + a) >> 2][31 - 8 * (a % 4) -: 8] = 8'(rand_below(256));
      end
      for (int i = 0; i < 160; i++) begin
         mem[(RES_SLOT >> 2) + i] = fill_word((RES_SLOT >> 2) + i);
      end
      wr_q.delete();
   endtask

   task automatic wait_done(input logic level, input int limit, input string what,
                            output bit ok);
      int n;
      n = 0;
      while (done !== level && n < limit) begin
         @(posedge clk);
         #1;
         n++;
      end
      ok = (done === level);
      if (!ok) begin
         report_timeout(what);
      end
   endtask

   task automatic check_results(input bit saturate);
      int          npix;
      int          base;
      logic [31:0] exp_w;
      npix = cfg.pixels;
      base = cfg.res_base >> 2;
      assert (wr_q.size() == 2 * npix)
         else report_error($sformatf("%0d writes, expected %0d", wr_q.size(), 2 * npix));
      for (int i = 0; i < wr_q.size(); i++) begin
         for (int j = i + 1; j < wr_q.size(); j++) begin
            assert (wr_q[i] != wr_q[j])
               else report_error($sformatf("address %h written twice", wr_q[i]));
         end
      end
      for (int k = 0; k < 2 * npix; k++) begin
         exp_w = expect_word(k / 2, k % 2);
         assert (mem[base + k] === exp_w)
            else report_error($sformatf("pixel %0d word %0d: got %h, expected %h",
                                        k / 2, k % 2, mem[base + k], exp_w));
         if (saturate) begin
            exp_w = (k % 2 == 0) ? 32'hffff_ffff : 32'h0000_0000;
            assert (mem[base + k] === exp_w)
               else report_error($sformatf("pixel %0d word %0d not saturated: %h",
                                           k / 2, k % 2, mem[base + k]));
         end
      end
      for (int g = 1; g <= 4; g++) begin
         assert (mem[base - g] === fill_word(base - g)
                 && mem[base + 2 * npix - 1 + g] === fill_word(base + 2 * npix - 1 + g))
            else report_error($sformatf("fill pattern overwritten %0d words off results", g));
      end
   endtask

   task automatic run_conv(input bit saturate);
      bit ok;
      int hold;
      setup_run(saturate);
      start = 1'b1;
      wait_done(1'b1, DONE_TMO, "o_done rising after start", ok);
      if (ok) begin
         hold = 1 + rand_below(4);
         for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #1;
            assert (done === 1'b1) else report_error("o_done fell while i_start high");
         end
         start = 1'b0;   // next run follows straight away
         wait_done(1'b0, DROP_TMO, "o_done falling after i_start low", ok);
         check_results(saturate);
      end
   endtask

   initial begin
      int n;
      start     = 1'b0;
      cfg       = '0;
      wb_rsp    = '0;
      busy      = 1'b0;
      wait_left = 0;
      errors    = 0;
      timeouts  = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = fill_word(i);
      end
      n = 0;
      while (rstn !== 1'b1 && n < 10) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (rstn !== 1'b1) begin
         report_timeout("reset release");
      end
      assert (done === 1'b0 && wb_req.cyc === 1'b0 && wb_req.stb === 1'b0
              && wb_req.we === 1'b0)
         else report_error("outputs not idle after reset");
      for (int r = 0; r < RUNS && timeouts == 0; r++) begin
         run_conv(r == 5);   // one run with saturating biases
      end
      $display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- flist.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/conv_wb_master.sv
hdl/conv_seq.sv
hdl/conv_filter_ram.sv
hdl/conv_mac_array.sv
hdl/conv_requant.sv
hdl/conv2d_top.sv
tb/conv_clk_gen.sv
tb/conv_wb_chk.sv
tb/conv_tb.sv

//--- Bender.yml
package:
  name: conv2d

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/conv_pkg.sv
      - hdl/conv_wb_master.sv
      - hdl/conv_seq.sv
      - hdl/conv_filter_ram.sv
      - hdl/conv_mac_array.sv
      - hdl/conv_requant.sv
      - hdl/conv2d_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/conv_clk_gen.sv
      - tb/conv_wb_chk.sv
      - tb/conv_tb.sv
